/* axi_read_port.sv */
// ----------------------------------------
// Registered AR and R slices, no flow control
// Readies reach the other side one cycle late
// ----------------------------------------
`timescale 1ns/1ps

module axi_read_port import glay_pkg::*; #(
  parameter int ADDR_W        = addr_w_default,
  parameter int DATA_W        = data_w_default,
  parameter int OUTSTANDING_W = outstanding_w_default
) (
  input  logic              ap_clk,
  input  logic              rst_int,
  input  logic              endian_read,
  // Memory side
  output logic              m_axi_arvalid,
  input  logic              m_axi_arready,
  output logic [ADDR_W-1:0] m_axi_araddr,
  output logic [len_w-1:0]  m_axi_arlen,
  input  logic              m_axi_rvalid,
  output logic              m_axi_rready,
  input  logic [DATA_W-1:0] m_axi_rdata,
  input  logic              m_axi_rlast,
  // Compute unit side
  input  logic              cu_axi_arvalid,
  output logic              cu_axi_arready,
  input  logic [ADDR_W-1:0] cu_axi_araddr,
  input  logic [len_w-1:0]  cu_axi_arlen,
  output logic              cu_axi_rvalid,
  input  logic              cu_axi_rready,
  output logic [DATA_W-1:0] cu_axi_rdata,
  output logic              cu_axi_rlast,
  output logic              read_busy
);

  logic [max_data_w-1:0]    rdata_swap;  // Swapped read beat
  logic [OUTSTANDING_W-1:0] outstanding; // Bursts in flight
  logic                     ar_hs;       // Address accepted by memory
  logic                     r_end;       // Final beat accepted

  assign rdata_swap = swap_bytes(max_data_w'(m_axi_rdata), DATA_W / 8, endian_read);
  assign ar_hs      = m_axi_arvalid & m_axi_arready;
  assign r_end      = m_axi_rvalid & m_axi_rready & m_axi_rlast;

  // ----------------------------------------
  // Handshake slices
  // ----------------------------------------
  always_ff @(posedge ap_clk or posedge rst_int) begin
    if (rst_int) begin
      m_axi_arvalid  <= 1'b0;
      m_axi_rready   <= 1'b0;
      cu_axi_arready <= 1'b0;
      cu_axi_rvalid  <= 1'b0;
    end else begin
      m_axi_arvalid  <= cu_axi_arvalid; // Toward memory
      m_axi_rready   <= cu_axi_rready;
      cu_axi_arready <= m_axi_arready;  // Toward compute unit
      cu_axi_rvalid  <= m_axi_rvalid;
    end
  end

  // Payload slices
  always_ff @(posedge ap_clk) begin
    m_axi_araddr <= cu_axi_araddr;
    m_axi_arlen  <= cu_axi_arlen;
    cu_axi_rdata <= rdata_swap[DATA_W-1:0]; // Byte order per descriptor flag
    cu_axi_rlast <= m_axi_rlast;
  end

  // ----------------------------------------
  // Outstanding burst count
  // ----------------------------------------
  always_ff @(posedge ap_clk or posedge rst_int) begin
    if (rst_int) begin
      outstanding <= '0;
    end else begin
      case ({ar_hs, r_end})
        2'b10:   outstanding <= outstanding + 1'b1; // New burst
        2'b01:   outstanding <= outstanding - 1'b1; // Burst complete
        default: outstanding <= outstanding;        // None or both
      endcase
    end
  end

  assign read_busy = |outstanding;

endmodule : axi_read_port

/* axi_write_port.sv */
// ----------------------------------------
// Registered AW, W and B slices, no flow control
// Readies reach the other side one cycle late
// ----------------------------------------
`timescale 1ns/1ps

module axi_write_port import glay_pkg::*; #(
  parameter int ADDR_W        = addr_w_default,
  parameter int DATA_W        = data_w_default,
  parameter int OUTSTANDING_W = outstanding_w_default
) (
  input  logic                ap_clk,
  input  logic                rst_int,
  input  logic                endian_write,
  // Memory side
  output logic                m_axi_awvalid,
  input  logic                m_axi_awready,
  output logic [ADDR_W-1:0]   m_axi_awaddr,
  output logic [len_w-1:0]    m_axi_awlen,
  output logic                m_axi_wvalid,
  input  logic                m_axi_wready,
  output logic [DATA_W-1:0]   m_axi_wdata,
  output logic [DATA_W/8-1:0] m_axi_wstrb,
  output logic                m_axi_wlast,
  input  logic                m_axi_bvalid,
  output logic                m_axi_bready,
  // Compute unit side
  input  logic                cu_axi_awvalid,
  output logic                cu_axi_awready,
  input  logic [ADDR_W-1:0]   cu_axi_awaddr,
  input  logic [len_w-1:0]    cu_axi_awlen,
  input  logic                cu_axi_wvalid,
  output logic                cu_axi_wready,
  input  logic [DATA_W-1:0]   cu_axi_wdata,
  input  logic [DATA_W/8-1:0] cu_axi_wstrb,
  input  logic                cu_axi_wlast,
  output logic                cu_axi_bvalid,
  input  logic                cu_axi_bready,
  output logic                write_busy
);

  logic [max_data_w-1:0]    wdata_swap;  // Swapped write beat
  logic [OUTSTANDING_W-1:0] outstanding; // Bursts awaiting response
  logic                     aw_hs;       // Address accepted by memory
  logic                     b_hs;        // Response accepted

  assign wdata_swap = swap_bytes(max_data_w'(cu_axi_wdata), DATA_W / 8, endian_write);
  assign aw_hs      = m_axi_awvalid & m_axi_awready;
  assign b_hs       = m_axi_bvalid & m_axi_bready;

  // ----------------------------------------
  // Handshake slices
  // ----------------------------------------
  always_ff @(posedge ap_clk or posedge rst_int) begin
    if (rst_int) begin
      m_axi_awvalid  <= 1'b0;
      m_axi_wvalid   <= 1'b0;
      m_axi_bready   <= 1'b0;
      cu_axi_awready <= 1'b0;
      cu_axi_wready  <= 1'b0;
      cu_axi_bvalid  <= 1'b0;
    end else begin
      m_axi_awvalid  <= cu_axi_awvalid; // Toward memory
      m_axi_wvalid   <= cu_axi_wvalid;
      m_axi_bready   <= cu_axi_bready;
      cu_axi_awready <= m_axi_awready;  // Toward compute unit
      cu_axi_wready  <= m_axi_wready;
      cu_axi_bvalid  <= m_axi_bvalid;
    end
  end

  // Payload slices
  always_ff @(posedge ap_clk) begin
    m_axi_awaddr <= cu_axi_awaddr;
    m_axi_awlen  <= cu_axi_awlen;
    m_axi_wdata  <= wdata_swap[DATA_W-1:0]; // Byte order per descriptor flag
    m_axi_wstrb  <= cu_axi_wstrb;           // Strobes never swapped
    m_axi_wlast  <= cu_axi_wlast;
  end

  // ----------------------------------------
  // Outstanding burst count
  // ----------------------------------------
  always_ff @(posedge ap_clk or posedge rst_int) begin
    if (rst_int) begin
      outstanding <= '0;
    end else begin
      case ({aw_hs, b_hs})
        2'b10:   outstanding <= outstanding + 1'b1; // New burst
        2'b01:   outstanding <= outstanding - 1'b1; // Response back
        default: outstanding <= outstanding;        // None or both
      endcase
    end
  end

  assign write_busy = |outstanding;

endmodule : axi_write_port

/* glay_pkg.sv */
// ----------------------------------------
// Shared widths and defaults for the kernel shell
// swap_bytes works on words up to max_data_w bits
// ----------------------------------------

package glay_pkg;

  // ----------------------------------------
  // Widths and defaults
  // ----------------------------------------
  localparam int addr_w_default        = 32;   // AXI address width
  localparam int data_w_default        = 64;   // AXI data width, whole bytes only
  localparam int len_w                 = 8;    // AXI4 burst length field
  localparam int num_buffers_default   = 4;    // Descriptor buffer count
  localparam int outstanding_w_default = 4;    // Outstanding burst counter width
  localparam int pulse_hold_default    = 16;   // Reset stretch in cycles
  localparam int max_data_w            = 1024; // Widest AXI4 data bus
  localparam int max_bytes             = max_data_w / 8;

  // ----------------------------------------
  // Descriptor flags in buffer 0
  // ----------------------------------------
  // Buffers are aligned, so the low address bits carry flags
  localparam int flag_endian_read  = 0; // Swap read data
  localparam int flag_endian_write = 1; // Swap write data

  // Reverses the first nbytes bytes of data when enable is set
  function automatic logic [max_data_w-1:0] swap_bytes(
    input logic [max_data_w-1:0] data,
    input int                    nbytes,
    input logic                  enable
  );
    logic [max_data_w-1:0] result;
    result = data;                              // Pass through by default
    if (enable) begin
      for (int i = 0; i < max_bytes; i++) begin
        if (i < nbytes) begin                   // Only bytes of the real word
          result[i*8 +: 8] = data[(nbytes-1-i)*8 +: 8];
        end
      end
    end
    return result;
  endfunction

endpackage : glay_pkg

/* kernel_control.sv */
// ----------------------------------------
// Start, ready, done, idle and continue chain
// ap_done waits for cu_done and for both ports to drain
// ----------------------------------------
`timescale 1ns/1ps

module kernel_control import glay_pkg::*; #(
  parameter int ADDR_W      = addr_w_default,
  parameter int NUM_BUFFERS = num_buffers_default
) (
  input  logic                                ap_clk,
  input  logic                                rst_int,
  input  logic                                ap_start,
  input  logic                                ap_continue,
  input  logic [NUM_BUFFERS-1:0][ADDR_W-1:0] buffers,
  input  logic                                cu_done,
  input  logic                                read_busy,
  input  logic                                write_busy,
  output logic                                ap_idle,
  output logic                                ap_ready,
  output logic                                ap_done,
  output logic                                cu_start,
  output logic [NUM_BUFFERS-1:0][ADDR_W-1:0] cu_buffers,
  output logic                                endian_read,
  output logic                                endian_write
);

  typedef enum logic [1:0] {
    st_idle,  // Waiting for ap_start
    st_busy,  // Compute unit running
    st_done   // ap_done held until ap_continue
  } ctrl_state_t;

  ctrl_state_t state;
  logic        done_seen;     // cu_done arrived, ports still busy
  logic        start_hit;     // Start accepted this cycle
  logic        ports_drained; // No burst in flight on either port

  assign start_hit     = (state == st_idle) & ap_start;
  assign ports_drained = ~read_busy & ~write_busy;

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------
  always_ff @(posedge ap_clk or posedge rst_int) begin
    if (rst_int) begin
      state        <= st_idle;
      done_seen    <= 1'b0;
      ap_ready     <= 1'b0;
      cu_start     <= 1'b0;
      endian_read  <= 1'b0;
      endian_write <= 1'b0;
    end else begin
      ap_ready <= start_hit; // One cycle pulse
      cu_start <= start_hit; // Same cycle as ap_ready
      case (state)
        st_idle: begin
          if (ap_start) begin
            state        <= st_busy;
            done_seen    <= 1'b0;
            endian_read  <= buffers[0][flag_endian_read];  // Flags from buffer 0
            endian_write <= buffers[0][flag_endian_write];
          end
        end
        st_busy: begin
          if ((cu_done | done_seen) & ports_drained) begin
            state     <= st_done;  // ap_done next cycle
            done_seen <= 1'b0;
          end else if (cu_done) begin
            done_seen <= 1'b1;     // Remember until drained
          end
        end
        st_done: begin
          if (ap_continue) begin
            state <= st_idle;      // Host acknowledged
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Descriptor latch, held until the next start
  always_ff @(posedge ap_clk) begin
    if (start_hit) begin
      cu_buffers <= buffers;
    end
  end

  assign ap_idle = (state == st_idle);
  assign ap_done = (state == st_done);

endmodule : kernel_control

/* kernel_reset_sync.sv */
// ----------------------------------------
// Holds rst_int for PULSE_HOLD cycles after ap_rst_n rises
// PULSE_HOLD must be at least 1
// ----------------------------------------
`timescale 1ns/1ps

module kernel_reset_sync import glay_pkg::*; #(
  parameter int PULSE_HOLD = pulse_hold_default
) (
  input  logic ap_clk,
  input  logic ap_rst_n,
  output logic rst_int
);

  logic [PULSE_HOLD-1:0] hold_sr; // Stretch chain

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      hold_sr <= '1;          // Assert at once
    end else begin
      hold_sr <= hold_sr << 1; // Shift in a zero each cycle
    end
  end

  assign rst_int = hold_sr[PULSE_HOLD-1]; // Last stage drives all blocks

endmodule : kernel_reset_sync

/* kernel_shell.sv */
// ----------------------------------------
// Kernel shell around the compute unit, one AXI4 master
// Compute unit must allow for readies one cycle late
// ----------------------------------------
`timescale 1ns/1ps

module kernel_shell import glay_pkg::*; #(
  parameter int ADDR_W        = addr_w_default,
  parameter int DATA_W        = data_w_default,
  parameter int NUM_BUFFERS   = num_buffers_default,
  parameter int OUTSTANDING_W = outstanding_w_default,
  parameter int PULSE_HOLD    = pulse_hold_default
) (
  input  logic                               ap_clk,
  input  logic                               ap_rst_n,
  // Host control chain
  input  logic                               ap_start,
  input  logic                               ap_continue,
  output logic                               ap_idle,
  output logic                               ap_ready,
  output logic                               ap_done,
  input  logic [NUM_BUFFERS-1:0][ADDR_W-1:0] buffers,
  // Compute unit control
  output logic                               cu_start,
  input  logic                               cu_done,
  output logic [NUM_BUFFERS-1:0][ADDR_W-1:0] cu_buffers,
  // Memory side AXI4 master
  output logic                               m_axi_arvalid,
  input  logic                               m_axi_arready,
  output logic [ADDR_W-1:0]                  m_axi_araddr,
  output logic [len_w-1:0]                   m_axi_arlen,
  input  logic                               m_axi_rvalid,
  output logic                               m_axi_rready,
  input  logic [DATA_W-1:0]                  m_axi_rdata,
  input  logic                               m_axi_rlast,
  output logic                               m_axi_awvalid,
  input  logic                               m_axi_awready,
  output logic [ADDR_W-1:0]                  m_axi_awaddr,
  output logic [len_w-1:0]                   m_axi_awlen,
  output logic                               m_axi_wvalid,
  input  logic                               m_axi_wready,
  output logic [DATA_W-1:0]                  m_axi_wdata,
  output logic [DATA_W/8-1:0]                m_axi_wstrb,
  output logic                               m_axi_wlast,
  input  logic                               m_axi_bvalid,
  output logic                               m_axi_bready,
  // Compute unit side
  input  logic                               cu_axi_arvalid,
  output logic                               cu_axi_arready,
  input  logic [ADDR_W-1:0]                  cu_axi_araddr,
  input  logic [len_w-1:0]                   cu_axi_arlen,
  output logic                               cu_axi_rvalid,
  input  logic                               cu_axi_rready,
  output logic [DATA_W-1:0]                  cu_axi_rdata,
  output logic                               cu_axi_rlast,
  input  logic                               cu_axi_awvalid,
  output logic                               cu_axi_awready,
  input  logic [ADDR_W-1:0]                  cu_axi_awaddr,
  input  logic [len_w-1:0]                   cu_axi_awlen,
  input  logic                               cu_axi_wvalid,
  output logic                               cu_axi_wready,
  input  logic [DATA_W-1:0]                  cu_axi_wdata,
  input  logic [DATA_W/8-1:0]                cu_axi_wstrb,
  input  logic                               cu_axi_wlast,
  output logic                               cu_axi_bvalid,
  input  logic                               cu_axi_bready
);

  logic rst_int;      // Stretched reset for every block
  logic read_busy;    // Read bursts in flight
  logic write_busy;   // Write bursts awaiting response
  logic endian_read;  // Read data swap enable
  logic endian_write; // Write data swap enable

  kernel_reset_sync #(
    .PULSE_HOLD(PULSE_HOLD)
  ) i_reset_sync (.*);

  axi_read_port #(
    .ADDR_W       (ADDR_W),
    .DATA_W       (DATA_W),
    .OUTSTANDING_W(OUTSTANDING_W)
  ) i_read_port (.*);

  axi_write_port #(
    .ADDR_W       (ADDR_W),
    .DATA_W       (DATA_W),
    .OUTSTANDING_W(OUTSTANDING_W)
  ) i_write_port (.*);

  kernel_control #(
    .ADDR_W     (ADDR_W),
    .NUM_BUFFERS(NUM_BUFFERS)
  ) i_control (.*);

endmodule : kernel_shell

/* run_sim.sh */
#!/bin/sh
# Build and run the kernel shell testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_kernel_shell -f sim.f -o tb_kernel_shell
./obj_dir/tb_kernel_shell | tee sim.log
if grep -q "SIMULATION PASSED" sim.log; then
  echo "Run passed"
else
  echo "Run failed, see sim.log"
  exit 1
fi

/* sim.f */
glay_pkg.sv
kernel_reset_sync.sv
kernel_control.sv
axi_read_port.sv
axi_write_port.sv
kernel_shell.sv
tb_kernel_shell.sv

/* tb_kernel_shell.sv */
// ----------------------------------------
// Testbench for the kernel shell at default parameters
// Random AXI traffic from an LFSR, burst counts tracked by a local model
// ----------------------------------------
`timescale 1ns/1ps

module tb_kernel_shell import glay_pkg::*;;

  localparam int ADDR_W      = addr_w_default;
  localparam int DATA_W      = data_w_default;
  localparam int STRB_W      = DATA_W / 8;
  localparam int NUM_BUFFERS = num_buffers_default;
  localparam int PULSE_HOLD  = pulse_hold_default;
  localparam int MAX_CYCLES  = 2000; // Reset plus five tests with margin

  logic ap_clk = 1'b0;
  logic ap_rst_n;
  logic ap_start, ap_continue, ap_idle, ap_ready, ap_done;
  logic cu_start, cu_done;
  logic [NUM_BUFFERS-1:0][ADDR_W-1:0] buffers, cu_buffers;
  // Memory side
  logic m_axi_arvalid, m_axi_arready, m_axi_rvalid, m_axi_rready, m_axi_rlast;
  logic m_axi_awvalid, m_axi_awready, m_axi_wvalid, m_axi_wready, m_axi_wlast;
  logic m_axi_bvalid, m_axi_bready;
  logic [ADDR_W-1:0] m_axi_araddr, m_axi_awaddr;
  logic [len_w-1:0]  m_axi_arlen, m_axi_awlen;
  logic [DATA_W-1:0] m_axi_rdata, m_axi_wdata;
  logic [STRB_W-1:0] m_axi_wstrb;
  // Compute unit side
  logic cu_axi_arvalid, cu_axi_arready, cu_axi_rvalid, cu_axi_rready, cu_axi_rlast;
  logic cu_axi_awvalid, cu_axi_awready, cu_axi_wvalid, cu_axi_wready, cu_axi_wlast;
  logic cu_axi_bvalid, cu_axi_bready;
  logic [ADDR_W-1:0] cu_axi_araddr, cu_axi_awaddr;
  logic [len_w-1:0]  cu_axi_arlen, cu_axi_awlen;
  logic [DATA_W-1:0] cu_axi_rdata, cu_axi_wdata;
  logic [STRB_W-1:0] cu_axi_wstrb;

  logic [31:0] lfsr_state = 32'hd410;  // Fixed seed
  int          cycle_cnt  = 0;
  int          errors     = 0;
  int          checks     = 0;
  int          test_mark  = 0;         // Error count at test start
  logic        cmp_en     = 1'b0;      // Set while random traffic runs
  logic        cmp_valid  = 1'b0;      // Expected values captured last edge
  logic        exp_sw_rd  = 1'b0;      // Swap flags the last start asked for
  logic        exp_sw_wr  = 1'b0;
  logic [3:0]  rd_cnt     = '0;        // Model of read bursts in flight
  logic [3:0]  wr_cnt     = '0;        // Model of write bursts awaiting B
  logic [ADDR_W+len_w+4:0]        exp_rd_ctl;
  logic [ADDR_W+len_w+STRB_W+6:0] exp_wr_ctl;
  logic [DATA_W-1:0]              exp_rdata, exp_wdata;

  kernel_shell #(
    .ADDR_W     (ADDR_W),
    .DATA_W     (DATA_W),
    .NUM_BUFFERS(NUM_BUFFERS),
    .PULSE_HOLD (PULSE_HOLD)
  ) i_dut (.*);

  always #4 ap_clk = ~ap_clk; // 8 ns period

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] rand_bits(input int nbits);
    logic [63:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < nbits; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[62:0], fb};
    end
    return bits;
  endfunction

  // Byte lane b moves to lane STRB_W-1-b when enabled
  function automatic logic [DATA_W-1:0] ref_swap(input logic [DATA_W-1:0] word, input logic en);
    logic [DATA_W-1:0] swapped;
    swapped = word;
    if (en) begin
      for (int b = 0; b < STRB_W; b++) begin
        swapped[DATA_W-8-8*b +: 8] = word[8*b +: 8];
      end
    end
    return swapped;
  endfunction

  task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("Test %0d %s: %0d errors", num, name, errors - test_mark);
    test_mark = errors;
  endtask

  // Random AXI inputs when rnd is set, all zero otherwise
  task automatic drive_axi(input logic rnd);
    m_axi_arready  = rnd ? 1'(rand_bits(1)) : 1'b0;
    m_axi_rvalid   = rnd ? 1'(rand_bits(1)) : 1'b0;
    m_axi_rdata    = rnd ? DATA_W'(rand_bits(DATA_W)) : '0;
    m_axi_rlast    = rnd ? 1'(rand_bits(1)) : 1'b0;
    m_axi_awready  = rnd ? 1'(rand_bits(1)) : 1'b0;
    m_axi_wready   = rnd ? 1'(rand_bits(1)) : 1'b0;
    m_axi_bvalid   = rnd ? 1'(rand_bits(1)) : 1'b0;
    cu_axi_arvalid = rnd ? 1'(rand_bits(1)) : 1'b0;
    cu_axi_araddr  = rnd ? ADDR_W'(rand_bits(ADDR_W)) : '0;
    cu_axi_arlen   = rnd ? len_w'(rand_bits(len_w)) : '0;
    cu_axi_rready  = rnd ? 1'(rand_bits(1)) : 1'b0;
    cu_axi_awvalid = rnd ? 1'(rand_bits(1)) : 1'b0;
    cu_axi_awaddr  = rnd ? ADDR_W'(rand_bits(ADDR_W)) : '0;
    cu_axi_awlen   = rnd ? len_w'(rand_bits(len_w)) : '0;
    cu_axi_wvalid  = rnd ? 1'(rand_bits(1)) : 1'b0;
    cu_axi_wdata   = rnd ? DATA_W'(rand_bits(DATA_W)) : '0;
    cu_axi_wstrb   = rnd ? STRB_W'(rand_bits(STRB_W)) : '0;
    cu_axi_wlast   = rnd ? 1'(rand_bits(1)) : 1'b0;
    cu_axi_bready  = rnd ? 1'(rand_bits(1)) : 1'b0;
  endtask

  task automatic random_buffers();
    buffers[1:0] = rand_bits(64);
    buffers[3:2] = rand_bits(64);
  endtask

  // Start from idle with the given swap flags in buffer 0
  task automatic start_run(input logic rd_flag, input logic wr_flag);
    logic [NUM_BUFFERS-1:0][ADDR_W-1:0] drv;
    random_buffers();
    buffers[0][flag_endian_read]  = rd_flag;
    buffers[0][flag_endian_write] = wr_flag;
    drv       = buffers;
    exp_sw_rd = rd_flag;
    exp_sw_wr = wr_flag;
    ap_start  = 1'b1;
    @(negedge ap_clk);
    ap_start = 1'b0;
    check_eq(ap_ready, 1'b1, "ap_ready pulse");
    check_eq(cu_start, 1'b1, "cu_start pulse");
    check_eq(ap_idle, 1'b0, "ap_idle falls on start");
    check_eq(cu_buffers, drv, "cu_buffers latched");
    random_buffers();                                // Latch must ignore new values
    @(negedge ap_clk);
    check_eq({ap_ready, cu_start}, 2'b00, "single ready and start pulse");
    check_eq(cu_buffers, drv, "cu_buffers held");
  endtask

  task automatic random_traffic(input int n);
    cmp_en = 1'b1;
    repeat (n) begin
      @(negedge ap_clk);
      drive_axi(1'b1);
    end
    @(negedge ap_clk);
    cmp_en = 1'b0;
    @(negedge ap_clk);                               // Last compare done
  endtask

  // Returns every burst the model still counts, on both ports
  task automatic drain_ports();
    drive_axi(1'b0);
    cu_axi_rready = 1'b1;
    cu_axi_bready = 1'b1;
    @(negedge ap_clk);                               // Readies reach memory side
    while (rd_cnt != 0 || wr_cnt != 0) begin
      m_axi_rvalid = (rd_cnt != 0);
      m_axi_rlast  = (rd_cnt != 0);
      m_axi_bvalid = (wr_cnt != 0);
      @(negedge ap_clk);
    end
    drive_axi(1'b0);
  endtask

  task automatic finish_run(input logic pulse_done, input int hold);
    int wait_cycles;
    drain_ports();
    if (pulse_done) begin
      cu_done = 1'b1;
      @(negedge ap_clk);
      cu_done = 1'b0;
    end
    wait_cycles = 0;
    while (!ap_done && wait_cycles < 20) begin
      @(negedge ap_clk);
      wait_cycles++;
    end
    if (!ap_done) begin
      errors++;
      $display("ERROR at %0t: ap_done did not rise after cu_done and drain", $time);
    end
    repeat (hold) begin
      @(negedge ap_clk);
      check_eq(ap_done, 1'b1, "ap_done held until continue");
    end
    ap_continue = 1'b1;
    @(negedge ap_clk);
    ap_continue = 1'b0;
    check_eq({ap_done, ap_idle}, 2'b01, "back to idle after continue");
  endtask

  // ----------------------------------------
  // Expected values and burst model
  // ----------------------------------------
  always @(posedge ap_clk) begin
    cmp_valid  <= cmp_en;
    rd_cnt     <= rd_cnt + 4'(m_axi_arvalid & m_axi_arready)
                         - 4'(m_axi_rvalid & m_axi_rready & m_axi_rlast);
    wr_cnt     <= wr_cnt + 4'(m_axi_awvalid & m_axi_awready)
                         - 4'(m_axi_bvalid & m_axi_bready);
    exp_rd_ctl <= {cu_axi_arvalid, cu_axi_araddr, cu_axi_arlen, cu_axi_rready,
                   m_axi_arready, m_axi_rvalid, m_axi_rlast};
    exp_wr_ctl <= {cu_axi_awvalid, cu_axi_awaddr, cu_axi_awlen, cu_axi_wvalid, cu_axi_wstrb,
                   cu_axi_wlast, cu_axi_bready, m_axi_awready, m_axi_wready, m_axi_bvalid};
    exp_rdata  <= ref_swap(m_axi_rdata, exp_sw_rd);
    exp_wdata  <= ref_swap(cu_axi_wdata, exp_sw_wr);
  end

  always @(negedge ap_clk) begin
    if (cmp_valid) begin
      check_eq({m_axi_arvalid, m_axi_araddr, m_axi_arlen, m_axi_rready,
                cu_axi_arready, cu_axi_rvalid, cu_axi_rlast}, exp_rd_ctl, "read slice");
      check_eq(cu_axi_rdata, exp_rdata, "cu_axi_rdata");
      check_eq({m_axi_awvalid, m_axi_awaddr, m_axi_awlen, m_axi_wvalid, m_axi_wstrb,
                m_axi_wlast, m_axi_bready, cu_axi_awready, cu_axi_wready, cu_axi_bvalid},
               exp_wr_ctl, "write slice");
      check_eq(m_axi_wdata, exp_wdata, "m_axi_wdata");
    end
  end

  always @(posedge ap_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  initial begin
    ap_rst_n    = 1'b0;
    ap_start    = 1'b0;
    ap_continue = 1'b0;
    cu_done     = 1'b0;
    buffers     = '0;
    drive_axi(1'b0);
    repeat (10) @(negedge ap_clk);
    ap_rst_n = 1'b1;
    repeat (PULSE_HOLD + 1) @(negedge ap_clk);       // Stretched reset released

    check_eq(ap_idle, 1'b1, "ap_idle after reset");
    check_eq({ap_ready, ap_done, cu_start}, 3'b000, "control outputs after reset");
    check_eq({m_axi_arvalid, m_axi_rready, m_axi_awvalid, m_axi_wvalid, m_axi_bready,
              cu_axi_arready, cu_axi_rvalid, cu_axi_awready, cu_axi_wready, cu_axi_bvalid},
             10'b0, "valid and ready outputs after reset");
    end_test(1, "after reset");

    start_run(1'b1, 1'b0);
    end_test(2, "start");

    random_traffic(50);
    end_test(3, "read path");

    finish_run(1'b1, 1);
    start_run(1'b0, 1'b1);
    random_traffic(50);
    end_test(4, "write path");

    drain_ports();
    cu_axi_arvalid = 1'b1;                           // One AR handshake at memory side
    m_axi_arready  = 1'b1;
    @(negedge ap_clk);
    cu_axi_arvalid = 1'b0;
    @(negedge ap_clk);
    m_axi_arready = 1'b0;
    check_eq(rd_cnt, 4'd1, "one read burst in flight");
    cu_done = 1'b1;
    @(negedge ap_clk);
    cu_done = 1'b0;
    repeat (5) begin
      @(negedge ap_clk);
      check_eq(ap_done, 1'b0, "ap_done held while read busy");
    end
    finish_run(1'b0, 3);                             // rlast beat releases ap_done
    start_run(1'b0, 1'b0);
    cu_done = 1'b1;
    check_eq(ap_done, 1'b0, "ap_done low with cu_done");
    @(negedge ap_clk);
    cu_done = 1'b0;
    check_eq(ap_done, 1'b1, "ap_done one cycle after cu_done");
    finish_run(1'b0, 2);
    end_test(5, "done gating");

    $display("Finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_kernel_shell
